// File: source/pipe_pkg.sv
// Shared definitions for the five-stage pipeline controller
// Widths, sequencer state encoding and the structs passed between blocks
package pipe_pkg;

	// Instruction word and word-address widths
	localparam int WORD_BITS    = 16;
	localparam int PC_BITS      = 15;
	// Register mask carried with each instruction for hazard checks
	localparam int HAZ_REG_BITS = 7;

	// Sequencer states
	typedef enum logic [3:0] {
		st_reset,
		st_pre_execute,
		st_execute,
		st_stall1,
		st_stall2,
		st_stall3,
		st_ins_stall1,
		st_ins_stall2,
		st_halt,
		st_halt2
	} pipe_state_t;

	// Registers written and flags modified by one instruction
	typedef struct packed {
		logic [HAZ_REG_BITS-1:0] haz_reg;
		logic                    modifies_flags;
	} haz_info_t;

	// One pipeline slot
	typedef struct packed {
		logic                 nop;
		logic [WORD_BITS-1:0] ins;
		logic [PC_BITS-1:0]   pc;
		haz_info_t            haz;
	} stage_slot_t;

	// Actions on the PC pair
	typedef enum logic [2:0] {
		pc_clear,
		pc_advance,
		pc_rewind,
		pc_load,
		pc_hold
	} pc_op_t;

	typedef struct packed {
		pc_op_t             op;
		logic [PC_BITS-1:0] target;
	} pc_cmd_t;

	// Per-cycle slot control
	typedef struct packed {
		logic kill0;
		logic kill1;
		logic kill2;
		logic kill34;
		logic hold1;
	} stage_ctrl_t;

endpackage

// File: source/fetch_unit.sv
`timescale 1ns/1ps
// Fetch side of the pipeline controller
// Holds the PC and the previous PC, applies the sequencer's PC command
// and registers the returned instruction word into slot 0
module fetch_unit (
	input  logic                           CLK,
	input  logic                           RSTb,
	input  pipe_pkg::pc_cmd_t              pc_cmd,
	input  logic                           kill0,
	input  logic [pipe_pkg::WORD_BITS-1:0] instruction_in,
	input  logic [pipe_pkg::PC_BITS-1:0]   instruction_address_in,
	output logic [pipe_pkg::PC_BITS-1:0]   instruction_address,
	output pipe_pkg::stage_slot_t          slot0
);
	import pipe_pkg::*;

	// Address being presented to memory
	logic [PC_BITS-1:0] pc_r;
	// Address presented one fetch earlier, used to refetch after a miss
	logic [PC_BITS-1:0] prev_pc_r;
	stage_slot_t        slot0_r;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc_r      <= '0;
			prev_pc_r <= '0;
		end else begin
			case (pc_cmd.op)
				pc_clear: begin
					pc_r      <= '0;
					prev_pc_r <= '0;
				end
				pc_advance: begin
					prev_pc_r <= pc_r;
					pc_r      <= pc_r + 1'b1;
				end
				// Previous PC stays, so a second miss rewinds to the same word
				pc_rewind: begin
					pc_r <= prev_pc_r;
				end
				// Branch target or halt resume address
				pc_load: begin
					pc_r      <= pc_cmd.target;
					prev_pc_r <= pc_cmd.target;
				end
				pc_hold: ;
				default: ;
			endcase
		end
	end

	// Memory answers one cycle after the address, so capture every cycle
	always_ff @(posedge CLK) begin
		slot0_r.nop <= kill0;
		slot0_r.ins <= instruction_in;
		slot0_r.pc  <= instruction_address_in;
		// Hazard info only joins at the decode slot
		slot0_r.haz <= '0;
	end

	assign instruction_address = pc_r;
	assign slot0               = slot0_r;

endmodule

// File: source/pipe_sequencer.sv
`timescale 1ns/1ps
// Pipeline sequencer
// Runs the pipeline state machine, latches halt requests and keeps the
// resume address, and turns each state into a PC command and slot control
module pipe_sequencer (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  logic                         instruction_valid,
	input  logic                         load_pc_request,
	input  logic [pipe_pkg::PC_BITS:0]   load_pc_address,
	input  logic                         halt_request,
	input  logic                         wake,
	input  logic                         hazard_1,
	input  logic                         hazard_2,
	input  logic                         hazard_3,
	input  logic [3:0]                   slot_nops,
	input  logic [pipe_pkg::PC_BITS-1:0] pc_stage2,
	output pipe_pkg::pc_cmd_t            pc_cmd,
	output pipe_pkg::stage_ctrl_t        stage_ctrl,
	output logic                         instruction_request
);
	import pipe_pkg::*;

	pipe_state_t        state_r;
	logic               halt_lat_r;
	logic [PC_BITS-1:0] halt_pc_r;
	logic               halt;
	logic               take_branch;
	logic               flush;
	logic               stall_1;
	logic               stall_2;
	logic               stall_3;

	// Halt request held until the halt state is reached
	assign halt        = halt_lat_r | halt_request;
	// Branch only counts with a live instruction in execute
	assign take_branch = load_pc_request & ~slot_nops[2];
	// Younger slots are discarded on a branch or a halt
	assign flush       = take_branch | halt;

	// Stall only if both compared slots hold real instructions
	assign stall_1 = hazard_1 & ~take_branch & ~slot_nops[0] & ~slot_nops[1];
	assign stall_2 = hazard_2 & ~take_branch & ~slot_nops[0] & ~slot_nops[2];
	assign stall_3 = hazard_3 & ~take_branch & ~slot_nops[0] & ~slot_nops[3];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_r <= st_reset;
		end else begin
			case (state_r)
				st_reset:       state_r <= st_pre_execute;
				st_pre_execute: state_r <= st_execute;
				// Priority: hazard, halt, branch, miss
				st_execute: begin
					if (stall_1)
						state_r <= st_stall1;
					else if (stall_2)
						state_r <= st_stall2;
					else if (stall_3)
						state_r <= st_stall3;
					else if (halt)
						state_r <= st_halt;
					else if (take_branch)
						state_r <= st_pre_execute;
					else if (!instruction_valid)
						state_r <= st_ins_stall1;
				end
				st_stall1:      state_r <= take_branch ? st_pre_execute : st_stall2;
				st_stall2:      state_r <= take_branch ? st_pre_execute : st_stall3;
				st_stall3:      state_r <= take_branch ? st_pre_execute : st_execute;
				// Wait one cycle while the PC rewinds
				st_ins_stall1:  state_r <= st_ins_stall2;
				st_ins_stall2: begin
					if (take_branch)
						state_r <= st_pre_execute;
					else if (instruction_valid)
						state_r <= st_execute;
				end
				st_halt:        state_r <= st_halt2;
				st_halt2:       state_r <= wake ? st_pre_execute : st_halt2;
				default:        state_r <= st_reset;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			halt_lat_r <= 1'b0;
		else if (state_r == st_halt)
			halt_lat_r <= 1'b0;
		else if (halt_request)
			halt_lat_r <= 1'b1;
	end

	// Resume after the halting instruction
	always_ff @(posedge CLK) begin
		if (halt_request)
			halt_pc_r <= pc_stage2 + 1'b1;
	end

	always_comb begin
		pc_cmd.op     = pc_hold;
		pc_cmd.target = load_pc_address[PC_BITS:1];
		case (state_r)
			st_reset:       pc_cmd.op = pc_clear;
			st_pre_execute: pc_cmd.op = pc_advance;
			st_execute: begin
				if (take_branch)
					pc_cmd.op = pc_load;
				else if (stall_1 || stall_2 || stall_3 || !instruction_valid)
					pc_cmd.op = pc_rewind;
				else
					pc_cmd.op = pc_advance;
			end
			st_stall1, st_stall2, st_ins_stall1: begin
				if (take_branch)
					pc_cmd.op = pc_load;
			end
			// Refetch of the stalled word starts here
			st_stall3:      pc_cmd.op = take_branch ? pc_load : pc_advance;
			st_ins_stall2: begin
				if (take_branch)
					pc_cmd.op = pc_load;
				else if (instruction_valid)
					pc_cmd.op = pc_advance;
			end
			st_halt: begin
				pc_cmd.op     = pc_load;
				pc_cmd.target = halt_pc_r;
			end
			default: ;
		endcase
	end

	always_comb begin
		// Fetch slot is only live in execute
		stage_ctrl.kill0  = (state_r != st_execute) | flush;
		stage_ctrl.hold1  = (state_r == st_stall1) | (state_r == st_stall2) |
			(state_r == st_stall3);
		stage_ctrl.kill34 = (state_r == st_reset);
		case (state_r)
			st_reset, st_pre_execute, st_halt, st_halt2: begin
				stage_ctrl.kill1 = 1'b1;
				stage_ctrl.kill2 = 1'b1;
			end
			// Word behind a miss is garbage
			st_ins_stall1: begin
				stage_ctrl.kill1 = 1'b1;
				stage_ctrl.kill2 = flush;
			end
			// Bubbles go into execute while decode waits
			st_stall1, st_stall2, st_stall3: begin
				stage_ctrl.kill1 = flush;
				stage_ctrl.kill2 = 1'b1;
			end
			default: begin
				stage_ctrl.kill1 = flush;
				stage_ctrl.kill2 = flush;
			end
		endcase
	end

	// Memory is released while halted
	assign instruction_request = (state_r != st_halt) && (state_r != st_halt2);

endmodule

// File: source/stage_chain.sv
`timescale 1ns/1ps
// Decode, execute, memory and writeback slots of the pipeline
// Moves instructions down one slot per cycle, holding decode during
// hazard stalls and forcing nops where the sequencer kills a slot
module stage_chain (
	input  logic                  CLK,
	input  pipe_pkg::stage_ctrl_t stage_ctrl,
	input  pipe_pkg::stage_slot_t slot0,
	input  pipe_pkg::haz_info_t   hazard_info0,
	output pipe_pkg::stage_slot_t slot1,
	output pipe_pkg::stage_slot_t slot2,
	output pipe_pkg::stage_slot_t slot3,
	output pipe_pkg::stage_slot_t slot4
);
	import pipe_pkg::*;

	stage_slot_t slot1_r;
	stage_slot_t slot2_r;
	stage_slot_t slot3_r;
	stage_slot_t slot4_r;

	// Decode slot
	always_ff @(posedge CLK) begin
		if (stage_ctrl.hold1) begin
			// Instruction stays put but can still be flushed
			slot1_r.nop <= slot1_r.nop | stage_ctrl.kill1;
		end else begin
			slot1_r.nop <= slot0.nop | stage_ctrl.kill1;
			slot1_r.ins <= slot0.ins;
			slot1_r.pc  <= slot0.pc;
			// Hazard info decoded from slot 0 joins here
			slot1_r.haz <= hazard_info0;
		end
	end

	// Execute slot
	always_ff @(posedge CLK) begin
		slot2_r     <= slot1_r;
		slot2_r.nop <= slot1_r.nop | stage_ctrl.kill2;
	end

	// Memory request and writeback slots
	always_ff @(posedge CLK) begin
		slot3_r     <= slot2_r;
		slot3_r.nop <= slot2_r.nop | stage_ctrl.kill34;
		slot4_r     <= slot3_r;
		slot4_r.nop <= slot3_r.nop | stage_ctrl.kill34;
	end

	assign slot1 = slot1_r;
	assign slot2 = slot2_r;
	assign slot3 = slot3_r;
	assign slot4 = slot4_r;

endmodule

// File: source/pipe_ctrl_top.sv
`timescale 1ns/1ps
// Pipeline controller for a 16-bit five-stage CPU
// Ties the fetch unit, sequencer and slot chain together and
// breaks the slots out into per-stage outputs
module pipe_ctrl_top (
	input  logic                           CLK,
	input  logic                           RSTb,
	output logic                           instruction_request,
	output logic [pipe_pkg::PC_BITS-1:0]   instruction_address,
	input  logic                           instruction_valid,
	input  logic [pipe_pkg::WORD_BITS-1:0] instruction_in,
	input  logic [pipe_pkg::PC_BITS-1:0]   instruction_address_in,
	input  logic                           load_pc_request,
	input  logic [pipe_pkg::PC_BITS:0]     load_pc_address,
	input  logic                           halt_request,
	input  logic                           wake,
	input  logic                           hazard_1,
	input  logic                           hazard_2,
	input  logic                           hazard_3,
	input  pipe_pkg::haz_info_t            hazard_info0,
	output pipe_pkg::haz_info_t            hazard_info1,
	output pipe_pkg::haz_info_t            hazard_info2,
	output pipe_pkg::haz_info_t            hazard_info3,
	output logic [pipe_pkg::WORD_BITS-1:0] pipeline_stage_0,
	output logic [pipe_pkg::WORD_BITS-1:0] pipeline_stage_1,
	output logic [pipe_pkg::WORD_BITS-1:0] pipeline_stage_2,
	output logic [pipe_pkg::WORD_BITS-1:0] pipeline_stage_3,
	output logic [pipe_pkg::WORD_BITS-1:0] pipeline_stage_4,
	output logic                           nop_stage_2,
	output logic                           nop_stage_4,
	output logic [pipe_pkg::PC_BITS:0]     pc_stage_4
);
	import pipe_pkg::*;

	pc_cmd_t     pc_cmd;
	stage_ctrl_t stage_ctrl;
	stage_slot_t slot0;
	stage_slot_t slot1;
	stage_slot_t slot2;
	stage_slot_t slot3;
	stage_slot_t slot4;

	fetch_unit u_fetch (
		.CLK                    (CLK),
		.RSTb                   (RSTb),
		.pc_cmd                 (pc_cmd),
		.kill0                  (stage_ctrl.kill0),
		.instruction_in         (instruction_in),
		.instruction_address_in (instruction_address_in),
		.instruction_address    (instruction_address),
		.slot0                  (slot0)
	);

	pipe_sequencer u_seq (
		.CLK                 (CLK),
		.RSTb                (RSTb),
		.instruction_valid   (instruction_valid),
		.load_pc_request     (load_pc_request),
		.load_pc_address     (load_pc_address),
		.halt_request        (halt_request),
		.wake                (wake),
		.hazard_1            (hazard_1),
		.hazard_2            (hazard_2),
		.hazard_3            (hazard_3),
		.slot_nops           ({slot3.nop, slot2.nop, slot1.nop, slot0.nop}),
		.pc_stage2           (slot2.pc),
		.pc_cmd              (pc_cmd),
		.stage_ctrl          (stage_ctrl),
		.instruction_request (instruction_request)
	);

	stage_chain u_chain (
		.CLK          (CLK),
		.stage_ctrl   (stage_ctrl),
		.slot0        (slot0),
		.hazard_info0 (hazard_info0),
		.slot1        (slot1),
		.slot2        (slot2),
		.slot3        (slot3),
		.slot4        (slot4)
	);

	assign pipeline_stage_0 = slot0.ins;
	assign pipeline_stage_1 = slot1.ins;
	assign pipeline_stage_2 = slot2.ins;
	assign pipeline_stage_3 = slot3.ins;
	assign pipeline_stage_4 = slot4.ins;
	assign hazard_info1     = slot1.haz;
	assign hazard_info2     = slot2.haz;
	assign hazard_info3     = slot3.haz;
	assign nop_stage_2      = slot2.nop;
	assign nop_stage_4      = slot4.nop;
	// Byte address of the writeback instruction
	assign pc_stage_4       = {slot4.pc, 1'b0};

endmodule

// File: include/tb_program.svh
// Test program for the pipeline controller testbench
// Gives the instruction word at each word address and the byte
// address of the instruction that follows it in program order
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Opcodes in the top nibble; plain instructions stay below 8
localparam logic [3:0] op_branch = 4'hb;
localparam logic [3:0] op_halt   = 4'hf;

// A few fixed halt locations, all on the branch loop
function automatic logic is_halt_addr(input logic [14:0] a);
	return (a == 15'h0043) || (a == 15'h00c5) || (a == 15'h0147);
endfunction

function automatic logic [15:0] prog_word(input logic [14:0] a);
	logic [8:0] target;
	// Each branch jumps to the next block of a loop of eight
	target = a[8:0] + 9'h035;
	if (is_halt_addr(a))
		return {op_halt, a[11:0]};
	// Branch every sixteen words, target in the low 12 bits
	if (a[3:0] == 4'hc)
		return {op_branch, 3'b000, target};
	return {1'b0, a[2:0], a[11:0]};
endfunction

// Byte address of the next instruction after ins at byte address pc
function automatic logic [15:0] next_pc(input logic [15:0] pc, input logic [15:0] ins);
	if (ins[15:12] == op_branch)
		return {3'b000, ins[11:0], 1'b0};
	return pc + 16'd2;
endfunction

`endif

// File: tests/tb_pipe_ctrl.sv
`timescale 1ns/1ps
// Testbench for the pipeline controller
// Models the instruction memory with random misses, drives branches,
// halts, wake and random hazards, and checks stage 4 program order
module tb_pipe_ctrl;
	`include "tb_program.svh"

	localparam int run_cycles    = 2000;
	localparam int retire_limit  = 200;
	localparam int halt_limit    = 16;

	logic        CLK;
	logic        RSTb;
	logic        instruction_request;
	logic [14:0] instruction_address;
	logic        instruction_valid;
	logic [15:0] instruction_in;
	logic [14:0] instruction_address_in;
	logic        load_pc_request;
	logic [15:0] load_pc_address;
	logic        halt_request;
	logic        wake;
	logic        hazard_1;
	logic        hazard_2;
	logic        hazard_3;
	logic [7:0]  hazard_info0;
	logic [7:0]  hazard_info1;
	logic [7:0]  hazard_info2;
	logic [7:0]  hazard_info3;
	logic [15:0] pipeline_stage_0;
	logic [15:0] pipeline_stage_1;
	logic [15:0] pipeline_stage_2;
	logic [15:0] pipeline_stage_3;
	logic [15:0] pipeline_stage_4;
	logic        nop_stage_2;
	logic        nop_stage_4;
	logic [15:0] pc_stage_4;

	// Address presented during the cycle that just ended
	logic [14:0] mem_addr_q;
	logic        checks_on;
	int          post_reset;
	logic [15:0] expected_pc;
	int          idle_cycles;
	// Halt tracking
	logic        halt_pending;
	int          halt_wait;
	logic        halted;
	int          wake_delay;

	pipe_ctrl_top uut (.*);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "Testbench stopped");
	endtask

	task automatic mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		stop_run("Value check failed");
	endtask

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK)
		mem_addr_q <= instruction_address;

	// Decode and execute hazard info must track its instruction
	a_haz1: assert property (@(posedge CLK) disable iff (!checks_on)
		hazard_info1 == pipeline_stage_1[7:0])
		else mismatch("hazard_info1", $sampled(hazard_info1), $sampled(pipeline_stage_1[7:0]));
	a_haz2: assert property (@(posedge CLK) disable iff (!checks_on)
		hazard_info2 == pipeline_stage_2[7:0])
		else mismatch("hazard_info2", $sampled(hazard_info2), $sampled(pipeline_stage_2[7:0]));
	a_haz3: assert property (@(posedge CLK) disable iff (!checks_on)
		hazard_info3 == pipeline_stage_3[7:0])
		else mismatch("hazard_info3", $sampled(hazard_info3), $sampled(pipeline_stage_3[7:0]));

	// Outputs are stable at the falling edge, so check and drive there
	always @(negedge CLK) begin
		if (RSTb) begin
			post_reset = post_reset + 1;
			if (post_reset <= 3) begin
				assert (nop_stage_2 && nop_stage_4 && instruction_request)
					else stop_run("Pipeline not idle with requests right after reset");
			end else begin
				checks_on = 1'b1;
			end
			// Retired instruction must be the program word, in program order
			if (!nop_stage_4) begin
				idle_cycles = 0;
				assert (pipeline_stage_4 == prog_word(pc_stage_4[15:1]))
					else mismatch("pipeline_stage_4", pipeline_stage_4,
						prog_word(pc_stage_4[15:1]));
				assert (pc_stage_4 == expected_pc)
					else mismatch("pc_stage_4", pc_stage_4, expected_pc);
				expected_pc = next_pc(pc_stage_4, pipeline_stage_4);
			end else if (!halted && !halt_pending) begin
				idle_cycles = idle_cycles + 1;
				assert (idle_cycles < retire_limit)
					else stop_run("Timeout waiting for an instruction to retire");
			end
			// Halt must drop the request in bounded time
			if (halt_pending) begin
				halt_wait = halt_wait + 1;
				if (!instruction_request) begin
					halt_pending = 1'b0;
					halted       = 1'b1;
					wake_delay   = 3 + int'($urandom % 8);
				end else begin
					assert (halt_wait < halt_limit)
						else stop_run("Timeout waiting for request to drop after halt");
				end
			end else if (halted) begin
				if (wake) begin
					halted = 1'b0;
				end else begin
					assert (!instruction_request)
						else stop_run("Instruction request rose before wake");
				end
			end
		end

		// Memory answers for the address of the previous cycle
		instruction_valid      = ($urandom % 100) >= 20;
		instruction_address_in = mem_addr_q;
		instruction_in         = instruction_valid ? prog_word(mem_addr_q) : 16'h7eed;
		hazard_1               = ($urandom % 100) < 10;
		hazard_2               = ($urandom % 100) < 8;
		hazard_3               = ($urandom % 100) < 6;
		hazard_info0           = pipeline_stage_0[7:0];

		// Execute-stage decisions from the instruction in stage 2
		load_pc_request = RSTb && !nop_stage_2 && pipeline_stage_2[15:12] == op_branch;
		load_pc_address = {3'b000, pipeline_stage_2[11:0], 1'b0};
		halt_request    = RSTb && !nop_stage_2 && pipeline_stage_2[15:12] == op_halt;
		if (halt_request) begin
			halt_pending = 1'b1;
			halt_wait    = 0;
		end

		wake = 1'b0;
		if (halted) begin
			if (wake_delay == 0)
				wake = 1'b1;
			else
				wake_delay = wake_delay - 1;
		end
	end

	initial begin
		void'($urandom(32'hd224));
		RSTb                   = 1'b0;
		instruction_valid      = 1'b0;
		instruction_in         = '0;
		instruction_address_in = '0;
		load_pc_request        = 1'b0;
		load_pc_address        = '0;
		halt_request           = 1'b0;
		wake                   = 1'b0;
		hazard_1               = 1'b0;
		hazard_2               = 1'b0;
		hazard_3               = 1'b0;
		hazard_info0           = '0;
		checks_on              = 1'b0;
		post_reset             = 0;
		expected_pc            = '0;
		idle_cycles            = 0;
		halt_pending           = 1'b0;
		halt_wait              = 0;
		halted                 = 1'b0;
		wake_delay             = 0;
		repeat (8) @(negedge CLK);
		RSTb = 1'b1;
		for (int i = 0; i < run_cycles; i++)
			@(negedge CLK);
		if (expected_pc == 16'h0000) begin
			$display("No instruction retired during the run");
			$display(">>> FAIL");
			$fatal(1, "Testbench stopped");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// File: vlog.f
+incdir+include
source/pipe_pkg.sv
source/fetch_unit.sv
source/pipe_sequencer.sv
source/stage_chain.sv
source/pipe_ctrl_top.sv
tests/tb_pipe_ctrl.sv

// File: run.sh
#!/bin/sh
# Builds the pipeline controller testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_pipe_ctrl --Mdir obj_dir -o sim_pipe_ctrl -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_pipe_ctrl 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx ">>> PASS"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
